/* common/processor_config.svh */
`ifndef PROCESSOR_CONFIG_SVH
`define PROCESSOR_CONFIG_SVH

// Datapath widths
`define WORD_WIDTH      32
`define REG_ADDR_WIDTH  5

// Instruction field positions
`define OPCODE_MSB      31
`define OPCODE_LSB      27
`define RD_MSB          26
`define RD_LSB          22
`define RS_MSB          21
`define RS_LSB          17
`define RT_MSB          16
`define RT_LSB          12
`define SHAMT_MSB       11
`define SHAMT_LSB       7
`define ALUOP_MSB       6
`define ALUOP_LSB       2
`define IMM_WIDTH       17

`define RESET_PC        32'h0000_0000

`endif

/* common/processorPkg.sv */
`default_nettype none

`include "processor_config.svh"

package processorPkg;

    typedef logic [`WORD_WIDTH-1:0] wordT;
    typedef logic [`REG_ADDR_WIDTH-1:0] regAddrT;

    // Instruction opcodes (bits 31:27)
    typedef enum logic [4:0] {
        opRtype = 5'd0,
        opJump  = 5'd1,
        opBne   = 5'd2,
        opAddi  = 5'd5,
        opBlt   = 5'd6,
        opSw    = 5'd7,
        opLw    = 5'd8
    } opcodeE;

    // R-type function field (bits 6:2)
    typedef enum logic [4:0] {
        aluAdd = 5'd0,
        aluSub = 5'd1,
        aluAnd = 5'd2,
        aluOr  = 5'd3,
        aluSll = 5'd4,
        aluSra = 5'd5
    } aluOpE;

    // Source of an execute operand
    typedef enum logic [1:0] {
        fwdRegFile,
        fwdMem,
        fwdWb
    } forwardSelE;

endpackage

`default_nettype wire

/* execute/alu.sv */
`timescale 1ns/1ps
`default_nettype none

module alu (
    input  processorPkg::wordT  operandA,
    input  processorPkg::wordT  operandB,
    input  processorPkg::aluOpE aluOp,
    input  logic [4:0]          shamt,
    output processorPkg::wordT  result
);

    always_comb begin
        case (aluOp)
            processorPkg::aluAdd: begin
                result = operandA + operandB;
            end
            processorPkg::aluSub: begin
                result = operandA - operandB;
            end
            processorPkg::aluAnd: begin
                result = operandA & operandB;
            end
            processorPkg::aluOr: begin
                result = operandA | operandB;
            end
            // Shifts take only operand A
            processorPkg::aluSll: begin
                result = operandA << shamt;
            end
            processorPkg::aluSra: begin
                result = $signed(operandA) >>> shamt;
            end
            default: begin
                result = operandA + operandB;
            end
        endcase
    end

endmodule

`default_nettype wire

/* execute/executeStage.sv */
`timescale 1ns/1ps
`default_nettype none

module executeStage (
    input  logic                     clock,
    input  logic                     reset,
    input  processorPkg::opcodeE     exOpcode,
    input  processorPkg::aluOpE      exAluOp,
    input  logic [4:0]               exShamt,
    input  processorPkg::wordT       exImm,
    input  processorPkg::wordT       exRsVal,
    input  processorPkg::wordT       exRtVal,
    input  processorPkg::regAddrT    exReadRegA,
    input  processorPkg::regAddrT    exReadRegB,
    input  processorPkg::regAddrT    exDest,
    input  processorPkg::wordT       exPcPlusOne,
    input  processorPkg::forwardSelE forwardA,
    input  processorPkg::forwardSelE forwardB,
    input  processorPkg::wordT       memForwardValue,
    input  processorPkg::wordT       wbForwardValue,
    output logic                     redirect,
    output processorPkg::wordT       redirectTarget,
    output processorPkg::wordT       memAluResult,
    output processorPkg::wordT       memStoreData,
    output processorPkg::regAddrT    memDest,
    output logic                     memRegWrite,
    output logic                     memIsLoad,
    output logic                     memIsStore
);

    processorPkg::wordT  operandA;
    processorPkg::wordT  operandB;
    processorPkg::wordT  aluOperandB;
    processorPkg::wordT  aluResult;
    processorPkg::aluOpE aluOpSel;
    logic                isRtype;
    logic                isAddi;
    logic                isLoad;
    logic                isStore;
    logic                isJump;
    logic                bneTaken;
    logic                bltTaken;

    function automatic processorPkg::wordT pickOperand(processorPkg::forwardSelE sel,
                                                       processorPkg::wordT regVal);
        case (sel)
            processorPkg::fwdMem: return memForwardValue;
            processorPkg::fwdWb:  return wbForwardValue;
            default:              return regVal;
        endcase
    endfunction

    assign isRtype = (exOpcode == processorPkg::opRtype);
    assign isAddi  = (exOpcode == processorPkg::opAddi);
    assign isLoad  = (exOpcode == processorPkg::opLw);
    assign isStore = (exOpcode == processorPkg::opSw);
    assign isJump  = (exOpcode == processorPkg::opJump);

    // --------------------
    // Operands and ALU
    // --------------------
    always_comb begin
        operandA = pickOperand(forwardA, exRsVal);
        operandB = pickOperand(forwardB, exRtVal);
    end

    // B stays intact for store data and branch compare
    assign aluOperandB = (isAddi || isLoad || isStore) ? exImm : operandB;
    assign aluOpSel    = isRtype ? exAluOp : processorPkg::aluAdd;

    alu alu_i (
        .operandA (operandA),
        .operandB (aluOperandB),
        .aluOp    (aluOpSel),
        .shamt    (exShamt),
        .result   (aluResult)
    );

    // --------------------
    // Branch resolution
    // --------------------
    // B holds rd, A holds rs
    assign bneTaken = (exOpcode == processorPkg::opBne) && (operandA != operandB);
    assign bltTaken = (exOpcode == processorPkg::opBlt) &&
                      ($signed(operandB) < $signed(operandA));

    assign redirect       = isJump || bneTaken || bltTaken;
    assign redirectTarget = isJump ? exImm : exPcPlusOne + exImm;

    // EX/MEM register
    always_ff @(posedge clock) begin
        if (reset) begin
            memRegWrite <= 1'b0;
            memIsLoad   <= 1'b0;
            memIsStore  <= 1'b0;
            memDest     <= '0;
        end else begin
            memRegWrite <= (isRtype || isAddi || isLoad) && (exDest != '0);
            memIsLoad   <= isLoad;
            memIsStore  <= isStore;
            memDest     <= exDest;
        end
    end

    always_ff @(posedge clock) begin
        memAluResult <= aluResult;
        memStoreData <= operandB;
    end

endmodule

`default_nettype wire

/* src/fetchStage.sv */
`timescale 1ns/1ps
`default_nettype none

`include "processor_config.svh"

module fetchStage (
    input  logic               clock,
    input  logic               reset,
    input  logic               stall,
    input  logic               redirect,
    input  processorPkg::wordT redirectTarget,
    output processorPkg::wordT addressImem,
    input  processorPkg::wordT qImem,
    output processorPkg::wordT ifInstr,
    output processorPkg::wordT ifPcPlusOne
);

    processorPkg::wordT pc;
    processorPkg::wordT pcPlusOne;

    assign pcPlusOne   = pc + 1'b1;
    assign addressImem = pc;

    // Redirect wins over stall
    always_ff @(posedge clock) begin
        if (reset) begin
            pc <= `RESET_PC;
        end else if (redirect) begin
            pc <= redirectTarget;
        end else if (!stall) begin
            pc <= pcPlusOne;
        end
    end

    // --------------------
    // IF/ID register
    // --------------------
    // An all-zero word decodes as a bubble
    always_ff @(posedge clock) begin
        if (reset || redirect) begin
            ifInstr <= '0;
        end else if (!stall) begin
            ifInstr <= qImem;
        end
    end

    always_ff @(posedge clock) begin
        if (!stall) begin
            ifPcPlusOne <= pcPlusOne;
        end
    end

endmodule

`default_nettype wire

/* src/decodeStage.sv */
`timescale 1ns/1ps
`default_nettype none

`include "processor_config.svh"

module decodeStage (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  stall,
    input  logic                  redirect,
    input  processorPkg::wordT    ifInstr,
    input  processorPkg::wordT    ifPcPlusOne,
    output processorPkg::regAddrT ctrlReadRegA,
    output processorPkg::regAddrT ctrlReadRegB,
    input  processorPkg::wordT    dataReadRegA,
    input  processorPkg::wordT    dataReadRegB,
    input  processorPkg::regAddrT wbDest,
    input  logic                  wbRegWrite,
    input  processorPkg::wordT    wbForwardValue,
    output processorPkg::opcodeE  exOpcode,
    output processorPkg::aluOpE   exAluOp,
    output logic [4:0]            exShamt,
    output processorPkg::wordT    exImm,
    output processorPkg::wordT    exRsVal,
    output processorPkg::wordT    exRtVal,
    output processorPkg::regAddrT exReadRegA,
    output processorPkg::regAddrT exReadRegB,
    output processorPkg::regAddrT exDest,
    output processorPkg::wordT    exPcPlusOne
);

    processorPkg::opcodeE  idOpcode;
    processorPkg::regAddrT rdField;
    processorPkg::wordT    immExt;
    processorPkg::wordT    rsVal;
    processorPkg::wordT    rtVal;

    assign idOpcode = processorPkg::opcodeE'(ifInstr[`OPCODE_MSB:`OPCODE_LSB]);
    assign rdField  = ifInstr[`RD_MSB:`RD_LSB];

    // Non-R-type instructions read rd as their second source
    assign ctrlReadRegA = ifInstr[`RS_MSB:`RS_LSB];
    assign ctrlReadRegB = (idOpcode == processorPkg::opRtype) ?
                          ifInstr[`RT_MSB:`RT_LSB] : rdField;

    // Jump carries its 27-bit target zero-extended in the immediate slot
    always_comb begin
        if (idOpcode == processorPkg::opJump) begin
            immExt = {{(`WORD_WIDTH - `OPCODE_LSB){1'b0}}, ifInstr[`OPCODE_LSB-1:0]};
        end else begin
            immExt = {{(`WORD_WIDTH - `IMM_WIDTH){ifInstr[`IMM_WIDTH-1]}},
                      ifInstr[`IMM_WIDTH-1:0]};
        end
    end

    // Writeback lands in the file only at the edge, so pick it up here
    assign rsVal = (wbRegWrite && wbDest == ctrlReadRegA) ? wbForwardValue : dataReadRegA;
    assign rtVal = (wbRegWrite && wbDest == ctrlReadRegB) ? wbForwardValue : dataReadRegB;

    // --------------------
    // ID/EX register
    // --------------------
    always_ff @(posedge clock) begin
        if (reset || stall || redirect) begin
            exOpcode <= processorPkg::opRtype;
            exAluOp  <= processorPkg::aluAdd;
            exDest   <= '0;
        end else begin
            exOpcode <= idOpcode;
            exAluOp  <= processorPkg::aluOpE'(ifInstr[`ALUOP_MSB:`ALUOP_LSB]);
            exDest   <= rdField;
        end
    end

    always_ff @(posedge clock) begin
        exShamt     <= ifInstr[`SHAMT_MSB:`SHAMT_LSB];
        exImm       <= immExt;
        exRsVal     <= rsVal;
        exRtVal     <= rtVal;
        exReadRegA  <= ctrlReadRegA;
        exReadRegB  <= ctrlReadRegB;
        exPcPlusOne <= ifPcPlusOne;
    end

endmodule

`default_nettype wire

/* src/hazardUnit.sv */
`timescale 1ns/1ps
`default_nettype none

module hazardUnit (
    input  processorPkg::regAddrT    ctrlReadRegA,
    input  processorPkg::regAddrT    ctrlReadRegB,
    input  processorPkg::opcodeE     exOpcode,
    input  processorPkg::regAddrT    exDest,
    input  processorPkg::regAddrT    exReadRegA,
    input  processorPkg::regAddrT    exReadRegB,
    input  processorPkg::regAddrT    memDest,
    input  logic                     memRegWrite,
    input  logic                     memIsLoad,
    input  processorPkg::regAddrT    wbDest,
    input  logic                     wbRegWrite,
    output logic                     stall,
    output processorPkg::forwardSelE forwardA,
    output processorPkg::forwardSelE forwardB
);

    // Youngest producer first; a load in MEM has no data yet
    function automatic processorPkg::forwardSelE selectSource(processorPkg::regAddrT src);
        if (src != '0 && memRegWrite && !memIsLoad && memDest == src) begin
            return processorPkg::fwdMem;
        end else if (src != '0 && wbRegWrite && wbDest == src) begin
            return processorPkg::fwdWb;
        end
        return processorPkg::fwdRegFile;
    endfunction

    always_comb begin
        forwardA = selectSource(exReadRegA);
        forwardB = selectSource(exReadRegB);
    end

    // Load in EX feeding the instruction in decode
    assign stall = (exOpcode == processorPkg::opLw) && (exDest != '0) &&
                   ((exDest == ctrlReadRegA) || (exDest == ctrlReadRegB));

endmodule

`default_nettype wire

/* src/memoryWriteback.sv */
`timescale 1ns/1ps
`default_nettype none

module memoryWriteback (
    input  logic                  clock,
    input  logic                  reset,
    input  processorPkg::wordT    memAluResult,
    input  processorPkg::wordT    memStoreData,
    input  processorPkg::regAddrT memDest,
    input  logic                  memRegWrite,
    input  logic                  memIsLoad,
    input  logic                  memIsStore,
    output processorPkg::wordT    addressDmem,
    output processorPkg::wordT    data,
    output logic                  wren,
    input  processorPkg::wordT    qDmem,
    output processorPkg::regAddrT wbDest,
    output logic                  wbRegWrite,
    output processorPkg::wordT    memForwardValue,
    output processorPkg::wordT    wbForwardValue,
    output logic                  ctrlWriteEnable,
    output processorPkg::regAddrT ctrlWriteReg,
    output processorPkg::wordT    dataWriteReg
);

    logic               wbIsLoad;
    processorPkg::wordT wbAluResult;
    processorPkg::wordT wbLoadData;

    // --------------------
    // Data memory
    // --------------------
    assign addressDmem = memAluResult;
    assign data        = memStoreData;
    assign wren        = memIsStore;

    // Only meaningful for non-load results
    assign memForwardValue = memAluResult;

    // MEM/WB register
    always_ff @(posedge clock) begin
        if (reset) begin
            wbRegWrite <= 1'b0;
            wbIsLoad   <= 1'b0;
            wbDest     <= '0;
        end else begin
            wbRegWrite <= memRegWrite;
            wbIsLoad   <= memIsLoad;
            wbDest     <= memDest;
        end
    end

    always_ff @(posedge clock) begin
        wbAluResult <= memAluResult;
        wbLoadData  <= qDmem;
    end

    // --------------------
    // Writeback
    // --------------------
    assign wbForwardValue  = wbIsLoad ? wbLoadData : wbAluResult;
    assign ctrlWriteEnable = wbRegWrite;
    assign ctrlWriteReg    = wbDest;
    assign dataWriteReg    = wbForwardValue;

endmodule

`default_nettype wire

/* src/processor.sv */
`timescale 1ns/1ps
`default_nettype none

module processor (
    input  logic                  clock,
    input  logic                  reset,
    output processorPkg::wordT    addressImem,
    input  processorPkg::wordT    qImem,
    output processorPkg::wordT    addressDmem,
    output processorPkg::wordT    data,
    output logic                  wren,
    input  processorPkg::wordT    qDmem,
    output logic                  ctrlWriteEnable,
    output processorPkg::regAddrT ctrlWriteReg,
    output processorPkg::regAddrT ctrlReadRegA,
    output processorPkg::regAddrT ctrlReadRegB,
    output processorPkg::wordT    dataWriteReg,
    input  processorPkg::wordT    dataReadRegA,
    input  processorPkg::wordT    dataReadRegB
);

    // --------------------
    // Hazard and redirect
    // --------------------
    logic                      stall;
    logic                      redirect;
    processorPkg::wordT        redirectTarget;
    processorPkg::forwardSelE  forwardA;
    processorPkg::forwardSelE  forwardB;

    // IF/ID
    processorPkg::wordT        ifInstr;
    processorPkg::wordT        ifPcPlusOne;

    // ID/EX
    processorPkg::opcodeE      exOpcode;
    processorPkg::aluOpE       exAluOp;
    logic [4:0]                exShamt;
    processorPkg::wordT        exImm;
    processorPkg::wordT        exRsVal;
    processorPkg::wordT        exRtVal;
    processorPkg::regAddrT     exReadRegA;
    processorPkg::regAddrT     exReadRegB;
    processorPkg::regAddrT     exDest;
    processorPkg::wordT        exPcPlusOne;

    // EX/MEM
    processorPkg::wordT        memAluResult;
    processorPkg::wordT        memStoreData;
    processorPkg::regAddrT     memDest;
    logic                      memRegWrite;
    logic                      memIsLoad;
    logic                      memIsStore;

    // MEM/WB and forwarding values
    processorPkg::wordT        memForwardValue;
    processorPkg::wordT        wbForwardValue;
    processorPkg::regAddrT     wbDest;
    logic                      wbRegWrite;

    // --------------------
    // Stages
    // --------------------
    // Port names match the wires above one to one
    fetchStage fetch_i (.*);

    decodeStage decode_i (.*);

    hazardUnit hazard_i (.*);

    executeStage execute_i (.*);

    memoryWriteback memWb_i (.*);

endmodule

`default_nettype wire

/* testbench/processorModel.svh */
`ifndef PROCESSOR_MODEL_SVH
`define PROCESSOR_MODEL_SVH

// Architectural state of the reference model
processorPkg::wordT    modelRegs [32];
processorPkg::wordT    modelMem [256];

// Expected results in program order
processorPkg::regAddrT expWriteReg [$];
processorPkg::wordT    expWriteData [$];
processorPkg::wordT    expStoreAddr [$];
processorPkg::wordT    expStoreData [$];

task automatic modelWrite(input processorPkg::regAddrT dest, input processorPkg::wordT value);
    // r0 stays zero and never shows up as a write
    if (dest != '0) begin
        modelRegs[dest] = value;
        expWriteReg.push_back(dest);
        expWriteData.push_back(value);
    end
endtask

// Executes one instruction at a time until the halting jump
task automatic runModel(input processorPkg::wordT instrMem [256], input int haltPc);
    processorPkg::wordT    instr;
    processorPkg::wordT    pc;
    processorPkg::wordT    a;
    processorPkg::wordT    b;
    processorPkg::wordT    imm;
    processorPkg::wordT    addr;
    processorPkg::regAddrT rd;
    logic [4:0]            shamt;
    pc = '0;
    while (pc < haltPc) begin
        instr = instrMem[pc[7:0]];
        rd    = instr[`RD_MSB:`RD_LSB];
        a     = modelRegs[instr[`RS_MSB:`RS_LSB]];
        b     = modelRegs[rd];
        imm   = {{(`WORD_WIDTH - `IMM_WIDTH){instr[`IMM_WIDTH-1]}}, instr[`IMM_WIDTH-1:0]};
        shamt = instr[`SHAMT_MSB:`SHAMT_LSB];
        addr  = a + imm;
        pc    = pc + 1;
        case (processorPkg::opcodeE'(instr[`OPCODE_MSB:`OPCODE_LSB]))
            processorPkg::opRtype: begin
                b = modelRegs[instr[`RT_MSB:`RT_LSB]];
                case (processorPkg::aluOpE'(instr[`ALUOP_MSB:`ALUOP_LSB]))
                    processorPkg::aluSub: modelWrite(rd, a - b);
                    processorPkg::aluAnd: modelWrite(rd, a & b);
                    processorPkg::aluOr:  modelWrite(rd, a | b);
                    processorPkg::aluSll: modelWrite(rd, a << shamt);
                    processorPkg::aluSra: modelWrite(rd, $signed(a) >>> shamt);
                    default:              modelWrite(rd, a + b);
                endcase
            end
            processorPkg::opAddi: modelWrite(rd, a + imm);
            processorPkg::opLw:   modelWrite(rd, modelMem[addr[7:0]]);
            processorPkg::opSw: begin
                modelMem[addr[7:0]] = b;
                expStoreAddr.push_back(addr);
                expStoreData.push_back(b);
            end
            // Branches compare rd against rs
            processorPkg::opBne: if (a != b) pc = pc + imm;
            processorPkg::opBlt: if ($signed(b) < $signed(a)) pc = pc + imm;
            processorPkg::opJump: pc = {5'b0, instr[26:0]};
            default: ;
        endcase
    end
endtask

`endif

/* testbench/processorTb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "processor_config.svh"

module processorTb;

    localparam int          CLOCK_PERIOD    = 4;
    localparam int          RESET_CYCLES    = 16;
    localparam int          PROGRAM_LEN     = 64;
    localparam int          HALT_PC         = PROGRAM_LEN;
    localparam int          DRAIN_CYCLES    = 8;
    localparam int          WATCHDOG_CYCLES = RESET_CYCLES + 4 * (PROGRAM_LEN + 1) + 100;
    localparam int unsigned SEED            = 32'hd730;

    logic                  clock;
    logic                  reset;
    processorPkg::wordT    addressImem;
    processorPkg::wordT    qImem;
    processorPkg::wordT    addressDmem;
    processorPkg::wordT    data;
    logic                  wren;
    processorPkg::wordT    qDmem;
    logic                  ctrlWriteEnable;
    processorPkg::regAddrT ctrlWriteReg;
    processorPkg::regAddrT ctrlReadRegA;
    processorPkg::regAddrT ctrlReadRegB;
    processorPkg::wordT    dataWriteReg;
    processorPkg::wordT    dataReadRegA;
    processorPkg::wordT    dataReadRegB;

    processorPkg::wordT    imem [256];
    processorPkg::wordT    dmem [256];
    processorPkg::wordT    regFile [32];
    int unsigned           writeCount;
    int unsigned           storeCount;

    `include "processorModel.svh"

    processor processor_i (
        .clock           (clock),
        .reset           (reset),
        .addressImem     (addressImem),
        .qImem           (qImem),
        .addressDmem     (addressDmem),
        .data            (data),
        .wren            (wren),
        .qDmem           (qDmem),
        .ctrlWriteEnable (ctrlWriteEnable),
        .ctrlWriteReg    (ctrlWriteReg),
        .ctrlReadRegA    (ctrlReadRegA),
        .ctrlReadRegB    (ctrlReadRegB),
        .dataWriteReg    (dataWriteReg),
        .dataReadRegA    (dataReadRegA),
        .dataReadRegB    (dataReadRegB)
    );

    // --------------------
    // Memories and register file
    // --------------------
    assign qImem        = imem[addressImem[7:0]];
    assign qDmem        = dmem[addressDmem[7:0]];
    assign dataReadRegA = regFile[ctrlReadRegA];
    assign dataReadRegB = regFile[ctrlReadRegB];

    always @(posedge clock) begin
        if (ctrlWriteEnable && ctrlWriteReg != '0) begin
            regFile[ctrlWriteReg] <= dataWriteReg;
        end
        if (wren) begin
            dmem[addressDmem[7:0]] <= data;
        end
    end

    initial begin
        clock = 1'b0;
        forever #(CLOCK_PERIOD / 2) clock = ~clock;
    end

    // --------------------
    // Failure reporting and compares
    // --------------------
    task automatic abortRun(input string reason);
        $display("%s", reason);
        $display(">>> FAIL");
        $fatal(1, "Simulation stopped on error");
    endtask

    task automatic checkFlag(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            abortRun($sformatf("[FAIL] %s: expected %b actual %b", name, expected, actual));
        end
    endtask

    task automatic checkWord(input string name, input processorPkg::wordT expected,
                             input processorPkg::wordT actual);
        if (actual !== expected) begin
            abortRun($sformatf("[FAIL] %s: expected %h actual %h", name, expected, actual));
        end
    endtask

    task automatic checkRegWrite(input processorPkg::regAddrT writeReg,
                                 input processorPkg::wordT writeData);
        processorPkg::regAddrT expReg;
        processorPkg::wordT    expData;
        if (expWriteReg.size() == 0) begin
            abortRun($sformatf("Register r%0d was written after the last expected write",
                               writeReg));
        end else begin
            expReg  = expWriteReg.pop_front();
            expData = expWriteData.pop_front();
            writeCount++;
            if (writeReg !== expReg || writeData !== expData) begin
                abortRun($sformatf("[FAIL] register write %0d: expected r%0d=%h actual r%0d=%h",
                                   writeCount, expReg, expData, writeReg, writeData));
            end
        end
    endtask

    task automatic checkStore(input processorPkg::wordT storeAddr,
                              input processorPkg::wordT storeValue);
        processorPkg::wordT expAddr;
        processorPkg::wordT expData;
        if (expStoreAddr.size() == 0) begin
            abortRun($sformatf("A store to address %h happened after the last expected store",
                               storeAddr));
        end else begin
            expAddr = expStoreAddr.pop_front();
            expData = expStoreData.pop_front();
            storeCount++;
            if (storeAddr !== expAddr || storeValue !== expData) begin
                abortRun($sformatf("[FAIL] store %0d: expected [%h]=%h actual [%h]=%h",
                                   storeCount, expAddr, expData, storeAddr, storeValue));
            end
        end
    endtask

    function automatic int firstRegMismatch();
        for (int i = 0; i < 32; i++) begin
            if (regFile[i] !== modelRegs[i]) begin
                return i;
            end
        end
        return -1;
    endfunction

    // --------------------
    // Random program
    // --------------------
    function automatic processorPkg::wordT randomInstr(int index);
        int unsigned           kind;
        int unsigned           room;
        int unsigned           offset;
        processorPkg::regAddrT rd;
        processorPkg::regAddrT rs;
        processorPkg::regAddrT rt;
        logic [4:0]            shamt;
        logic [4:0]            fn;
        logic [`IMM_WIDTH-1:0] imm;
        kind   = $urandom % 10;
        rd     = processorPkg::regAddrT'($urandom % 8);
        rs     = processorPkg::regAddrT'($urandom % 8);
        rt     = processorPkg::regAddrT'($urandom % 8);
        shamt  = 5'($urandom);
        fn     = 5'($urandom % 6);
        imm    = `IMM_WIDTH'($urandom);
        // Forward targets never pass the halting jump
        room   = HALT_PC - index - 1;
        offset = 1 + $urandom % 4;
        if (offset > room) begin
            offset = room;
        end
        if (kind >= 7 && room == 0) begin
            kind = 4;
        end
        case (kind)
            4: return {processorPkg::opAddi, rd, rs, imm};
            5: return {processorPkg::opLw, rd, rs, imm};
            6: return {processorPkg::opSw, rd, rs, imm};
            7: return {processorPkg::opBne, rd, rs, `IMM_WIDTH'(offset)};
            8: return {processorPkg::opBlt, rd, rs, `IMM_WIDTH'(offset)};
            9: return {processorPkg::opJump, 27'(index + 1 + offset)};
            default: return {processorPkg::opRtype, rd, rs, rt, shamt, fn, 2'b00};
        endcase
    endfunction

    task automatic buildProgram();
        // Unused words hold R-type ops to r0
        for (int i = 0; i < 256; i++) begin
            imem[i] = {10'd0, 22'(i)};
        end
        for (int i = 0; i < PROGRAM_LEN; i++) begin
            imem[i] = randomInstr(i);
        end
        imem[HALT_PC] = {processorPkg::opJump, 27'(HALT_PC)};
    endtask

    task automatic initState();
        processorPkg::wordT value;
        regFile[0]   <= '0;
        modelRegs[0]  = '0;
        for (int i = 1; i < 32; i++) begin
            value         = $urandom;
            regFile[i]   <= value;
            modelRegs[i]  = value;
        end
        for (int i = 0; i < 256; i++) begin
            value        = $urandom;
            dmem[i]     <= value;
            modelMem[i]  = value;
        end
    endtask

    // Every write and store is compared as it appears
    always @(negedge clock) begin
        if (ctrlWriteEnable) begin
            checkRegWrite(ctrlWriteReg, dataWriteReg);
        end
        if (wren) begin
            checkStore(addressDmem, data);
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * CLOCK_PERIOD);
        abortRun("Timeout: the processor hung before finishing the program");
    end

    // --------------------
    // Main sequence
    // --------------------
    initial begin
        int badReg;
        void'($urandom(SEED));
        reset      = 1'b1;
        writeCount = 0;
        storeCount = 0;
        buildProgram();
        initState();
        runModel(imem, HALT_PC);

        repeat (RESET_CYCLES) begin
            @(negedge clock);
            checkFlag("wren in reset", 1'b0, wren);
            checkFlag("ctrlWriteEnable in reset", 1'b0, ctrlWriteEnable);
            checkWord("addressImem in reset", `RESET_PC, addressImem);
        end
        reset = 1'b0;
        @(negedge clock);
        checkFlag("wren after reset", 1'b0, wren);
        checkFlag("ctrlWriteEnable after reset", 1'b0, ctrlWriteEnable);

        while (expWriteReg.size() != 0 || expStoreAddr.size() != 0) begin
            @(negedge clock);
        end
        // Quiet period so stray writes from the halt loop get caught
        repeat (DRAIN_CYCLES) begin
            @(negedge clock);
        end

        badReg = firstRegMismatch();
        if (badReg >= 0) begin
            abortRun($sformatf("[FAIL] final register file r%0d: expected %h actual %h",
                               badReg, modelRegs[badReg], regFile[badReg]));
        end else begin
            $display(">>> PASS");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* processor.f */
+incdir+common
+incdir+testbench
common/processorPkg.sv
execute/alu.sv
execute/executeStage.sv
src/fetchStage.sv
src/decodeStage.sv
src/hazardUnit.sv
src/memoryWriteback.sv
src/processor.sv
testbench/processorTb.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        ?= processorTb
RTL_TOP    ?= processor
FILELIST   ?= processor.f
BUILD_DIR  ?= obj_dir
VFLAGS     ?= --binary --timing -j 0
LINT_FLAGS ?= --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

# A $fatal in the testbench gives a nonzero exit status
run: build
	./$(BUILD_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR)
